// File: include/tetris_settings.svh
`ifndef TETRIS_SETTINGS_SVH
`define TETRIS_SETTINGS_SVH

// Playfield size
`define BOARD_ROWS 20
`define BOARD_COLS 10

// Anchor column for a new piece
`define SPAWN_COL 3

`define PIECE_KINDS 7
`define SCORE_MAX 255

`endif

// File: hw/tetris_pkg.sv
`include "tetris_settings.svh"

package tetris_pkg;

    // One board row, bit c is column c
    typedef logic [`BOARD_COLS-1:0] row_t;

    // Row 0 is the top of the playfield
    typedef row_t [`BOARD_ROWS-1:0] board_t;

    typedef logic [4:0] row_idx_t;
    typedef logic [4:0] piece_row_t;

    // Signed, shapes with an empty first column push the anchor to -1
    typedef logic signed [4:0] piece_col_t;

    // 0 I, 1 O, 2 L, 3 J, 4 S, 5 Z, 6 T
    typedef logic [2:0] piece_kind_t;

    typedef logic [7:0] score_t;

    // Indexed [row][col] inside the 4x4 cell
    typedef logic [3:0][3:0] shape_t;

    typedef enum logic [2:0] {
        IDLE,
        SPAWN,
        FALLING,
        LOCK,
        CLEAR,
        OVER
    } game_state_t;

endpackage

// File: hw/game_fsm.sv
`timescale 1ns/1ns

module game_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start_i,
    input  logic drop_tick_i,
    input  logic collide_bottom_i,
    input  logic clear_done_i,
    input  logic top_busy_i,
    output logic spawn_o,
    output logic step_down_o,
    output logic shift_en_o,
    output logic lock_o,
    output logic clear_start_o,
    output logic show_piece_o,
    output logic game_over_o
);
    import tetris_pkg::*;

    game_state_t state_q;
    game_state_t state_d;

    logic tick_falling;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = SPAWN;
                end
            end
            SPAWN: state_d = FALLING;
            FALLING: begin
                // Landing is only decided on a tick
                if (drop_tick_i && collide_bottom_i) begin
                    state_d = LOCK;
                end
            end
            LOCK: state_d = CLEAR;
            CLEAR: begin
                if (clear_done_i) begin
                    state_d = top_busy_i ? OVER : SPAWN;
                end
            end
            OVER: state_d = OVER;
            default: state_d = IDLE;
        endcase
    end

    assign tick_falling = (state_q == FALLING) && drop_tick_i;

    // Down step and lateral move share the tick
    assign step_down_o = tick_falling && !collide_bottom_i;
    assign shift_en_o = tick_falling && !collide_bottom_i;

    assign spawn_o = (state_q == SPAWN);
    assign lock_o = (state_q == LOCK);
    assign clear_start_o = (state_q == LOCK);
    assign show_piece_o = (state_q == FALLING);
    assign game_over_o = (state_q == OVER);

endmodule

// File: hw/piece_mover.sv
`timescale 1ns/1ns
`include "tetris_settings.svh"

module piece_mover (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    spawn_i,
    input  logic                    step_down_i,
    input  logic                    shift_en_i,
    input  logic                    left_i,
    input  logic                    right_i,
    input  logic                    collide_left_i,
    input  logic                    collide_right_i,
    output tetris_pkg::piece_row_t  row_o,
    output tetris_pkg::piece_col_t  col_o,
    output tetris_pkg::piece_kind_t kind_o
);
    import tetris_pkg::*;

    piece_row_t  row_q;
    piece_col_t  col_q;
    piece_kind_t kind_q;
    piece_kind_t next_kind_q;

    // Fixed cyclic order 0..6
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            next_kind_q <= '0;
        end else if (spawn_i) begin
            if (next_kind_q == piece_kind_t'(`PIECE_KINDS - 1)) begin
                next_kind_q <= '0;
            end else begin
                next_kind_q <= next_kind_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            row_q  <= '0;
            col_q  <= piece_col_t'(`SPAWN_COL);
            kind_q <= '0;
        end else if (spawn_i) begin
            row_q  <= '0;
            col_q  <= piece_col_t'(`SPAWN_COL);
            kind_q <= next_kind_q;
        end else begin
            if (step_down_i) begin
                row_q <= row_q + 1'b1;
            end
            // Collision flags refer to the position before this move
            if (shift_en_i) begin
                if (left_i && !collide_left_i) begin
                    col_q <= col_q - piece_col_t'(1);
                end else if (right_i && !collide_right_i) begin
                    col_q <= col_q + piece_col_t'(1);
                end
            end
        end
    end

    assign row_o  = row_q;
    assign col_o  = col_q;
    assign kind_o = kind_q;

endmodule

// File: hw/piece_geometry.sv
`timescale 1ns/1ns
`include "tetris_settings.svh"

module piece_geometry (
    input  tetris_pkg::piece_row_t  row_i,
    input  tetris_pkg::piece_col_t  col_i,
    input  tetris_pkg::piece_kind_t kind_i,
    input  tetris_pkg::board_t      board_i,
    output tetris_pkg::board_t      piece_cells_o,
    output logic                    collide_bottom_o,
    output logic                    collide_left_o,
    output logic                    collide_right_o
);
    import tetris_pkg::*;

    shape_t shape;

    // Shape table, each nibble is one row with bit c as column c
    always_comb begin
        shape = '0;
        case (kind_i)
            3'd0: begin
                shape[0] = 4'b0010;
                shape[1] = 4'b0010;
                shape[2] = 4'b0010;
                shape[3] = 4'b0010;
            end
            3'd1: begin
                shape[0] = 4'b0110;
                shape[1] = 4'b0110;
            end
            3'd2: begin
                shape[0] = 4'b0010;
                shape[1] = 4'b0010;
                shape[2] = 4'b0110;
            end
            3'd3: begin
                shape[0] = 4'b0100;
                shape[1] = 4'b0100;
                shape[2] = 4'b0110;
            end
            3'd4: begin
                shape[0] = 4'b1100;
                shape[1] = 4'b0110;
            end
            3'd5: begin
                shape[0] = 4'b0110;
                shape[1] = 4'b1100;
            end
            3'd6: begin
                shape[0] = 4'b0100;
                shape[1] = 4'b1110;
            end
            default: shape = '0;
        endcase
    end

    always_comb begin
        int ar;
        int ac;
        piece_cells_o    = '0;
        collide_bottom_o = 1'b0;
        collide_left_o   = 1'b0;
        collide_right_o  = 1'b0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                // Absolute cell, column may be negative
                ar = int'(row_i) + r;
                ac = int'(col_i) + c;
                if (shape[r][c] && ar < `BOARD_ROWS && ac >= 0 && ac < `BOARD_COLS) begin
                    piece_cells_o[ar][ac] = 1'b1;
                    if (ar >= `BOARD_ROWS - 1) begin
                        collide_bottom_o = 1'b1;
                    end else if (board_i[ar+1][ac]) begin
                        collide_bottom_o = 1'b1;
                    end
                    if (ac == 0) begin
                        collide_left_o = 1'b1;
                    end else if (board_i[ar][ac-1]) begin
                        collide_left_o = 1'b1;
                    end
                    if (ac == `BOARD_COLS - 1) begin
                        collide_right_o = 1'b1;
                    end else if (board_i[ar][ac+1]) begin
                        collide_right_o = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: hw/board_store.sv
`timescale 1ns/1ns
`include "tetris_settings.svh"

module board_store (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 lock_i,
    input  tetris_pkg::board_t   piece_cells_i,
    input  logic                 clear_start_i,
    input  logic                 show_piece_i,
    output tetris_pkg::board_t   board_o,
    output tetris_pkg::board_t   display_o,
    output tetris_pkg::score_t   score_o,
    output logic                 clear_done_o,
    output logic                 top_busy_o
);
    import tetris_pkg::*;

    board_t   board_q;
    board_t   shifted;
    row_idx_t scan_row_q;
    logic     scan_active_q;
    logic     row_full;
    score_t   score_q;

    assign row_full = scan_active_q && (&board_q[scan_row_q]);

    // Rows above the full one drop by one, row 0 comes in empty
    always_comb begin
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            if (r == 0) begin
                shifted[r] = '0;
            end else if (r <= int'(scan_row_q)) begin
                shifted[r] = board_q[r-1];
            end else begin
                shifted[r] = board_q[r];
            end
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            board_q <= '0;
        end else if (lock_i) begin
            board_q <= board_q | piece_cells_i;
        end else if (row_full) begin
            board_q <= shifted;
        end
    end

    // Bottom-up scan, stays on a row after a clear so cascades are caught
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            scan_active_q <= 1'b0;
            scan_row_q    <= '0;
            score_q       <= '0;
        end else if (clear_start_i) begin
            scan_active_q <= 1'b1;
            scan_row_q    <= row_idx_t'(`BOARD_ROWS - 1);
        end else if (scan_active_q) begin
            if (row_full) begin
                if (score_q != score_t'(`SCORE_MAX)) begin
                    score_q <= score_q + 1'b1;
                end
            end else if (scan_row_q == '0) begin
                scan_active_q <= 1'b0;
            end else begin
                scan_row_q <= scan_row_q - 1'b1;
            end
        end
    end

    assign clear_done_o = scan_active_q && !row_full && (scan_row_q == '0);
    assign top_busy_o   = |board_q[0];

    assign board_o   = board_q;
    assign score_o   = score_q;
    assign display_o = board_q | (show_piece_i ? piece_cells_i : '0);

endmodule

// File: hw/tetris_core.sv
`timescale 1ns/1ns

module tetris_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_i,
    input  logic                    drop_tick_i,
    input  logic                    left_i,
    input  logic                    right_i,
    output tetris_pkg::board_t      display_o,
    output tetris_pkg::piece_kind_t piece_kind_o,
    output tetris_pkg::score_t      score_o,
    output logic                    spawn_o,
    output logic                    lock_o,
    output logic                    game_over_o
);
    import tetris_pkg::*;

    logic       step_down;
    logic       shift_en;
    logic       clear_start;
    logic       show_piece;
    logic       clear_done;
    logic       top_busy;
    logic       collide_bottom;
    logic       collide_left;
    logic       collide_right;
    piece_row_t piece_row;
    piece_col_t piece_col;
    board_t     board;
    board_t     piece_cells;

    game_fsm u_fsm (
        .clk              (clk),
        .reset            (reset),
        .start_i          (start_i),
        .drop_tick_i      (drop_tick_i),
        .collide_bottom_i (collide_bottom),
        .clear_done_i     (clear_done),
        .top_busy_i       (top_busy),
        .spawn_o          (spawn_o),
        .step_down_o      (step_down),
        .shift_en_o       (shift_en),
        .lock_o           (lock_o),
        .clear_start_o    (clear_start),
        .show_piece_o     (show_piece),
        .game_over_o      (game_over_o)
    );

    piece_mover u_mover (
        .clk             (clk),
        .reset           (reset),
        .spawn_i         (spawn_o),
        .step_down_i     (step_down),
        .shift_en_i      (shift_en),
        .left_i          (left_i),
        .right_i         (right_i),
        .collide_left_i  (collide_left),
        .collide_right_i (collide_right),
        .row_o           (piece_row),
        .col_o           (piece_col),
        .kind_o          (piece_kind_o)
    );

    piece_geometry u_geometry (
        .row_i            (piece_row),
        .col_i            (piece_col),
        .kind_i           (piece_kind_o),
        .board_i          (board),
        .piece_cells_o    (piece_cells),
        .collide_bottom_o (collide_bottom),
        .collide_left_o   (collide_left),
        .collide_right_o  (collide_right)
    );

    board_store u_board (
        .clk           (clk),
        .reset         (reset),
        .lock_i        (lock_o),
        .piece_cells_i (piece_cells),
        .clear_start_i (clear_start),
        .show_piece_i  (show_piece),
        .board_o       (board),
        .display_o     (display_o),
        .score_o       (score_o),
        .clear_done_o  (clear_done),
        .top_busy_o    (top_busy)
    );

endmodule

// File: verif/tetris_tb.sv
`timescale 1ns/1ns
`include "tetris_settings.svh"

module tetris_tb;
    import tetris_pkg::*;

    localparam int WAIT_LIMIT = 100;
    localparam int TICK_LIMIT = 24;

    logic        clk;
    logic        reset;
    logic        start_i;
    logic        drop_tick_i;
    logic        left_i;
    logic        right_i;
    board_t      display_o;
    piece_kind_t piece_kind_o;
    score_t      score_o;
    logic        spawn_o;
    logic        lock_o;
    logic        game_over_o;

    // Reference model of the game
    board_t model_board;
    int     model_row;
    int     model_col;
    int     model_kind;
    int     next_kind;
    int     model_score;
    int     clear_count;

    tetris_core dut0 (
        .clk          (clk),
        .reset        (reset),
        .start_i      (start_i),
        .drop_tick_i  (drop_tick_i),
        .left_i       (left_i),
        .right_i      (right_i),
        .display_o    (display_o),
        .piece_kind_o (piece_kind_o),
        .score_o      (score_o),
        .spawn_o      (spawn_o),
        .lock_o       (lock_o),
        .game_over_o  (game_over_o)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name,
                     expected, actual);
            abort_run();
        end
    endtask

    task automatic check_board(input string name, input board_t expected, input board_t actual);
        assert (actual === expected) else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name,
                     expected, actual);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Cells of each shape inside its 4x4 cell
    function automatic bit shape_has(input int kind, input int r, input int c);
        case (kind)
            0: return c == 1;
            1: return r <= 1 && (c == 1 || c == 2);
            2: return (r <= 2 && c == 1) || (r == 2 && c == 2);
            3: return (r <= 2 && c == 2) || (r == 2 && c == 1);
            4: return (r == 0 && c >= 2) || (r == 1 && (c == 1 || c == 2));
            5: return (r == 0 && (c == 1 || c == 2)) || (r == 1 && c >= 2);
            6: return (r == 0 && c == 2) || (r == 1 && c >= 1);
            default: return 1'b0;
        endcase
    endfunction

    function automatic board_t overlay_of(input int prow, input int pcol, input int kind);
        board_t cells;
        int     ar;
        int     ac;
        cells = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                ar = prow + r;
                ac = pcol + c;
                if (shape_has(kind, r, c) && ar < `BOARD_ROWS && ac >= 0 && ac < `BOARD_COLS) begin
                    cells[ar][ac] = 1'b1;
                end
            end
        end
        return cells;
    endfunction

    // Flags as {bottom, left, right} against the model board
    function automatic logic [2:0] edge_flags(input int prow, input int pcol, input int kind);
        board_t     cells;
        logic [2:0] flags;
        cells = overlay_of(prow, pcol, kind);
        flags = '0;
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            for (int c = 0; c < `BOARD_COLS; c++) begin
                if (cells[r][c]) begin
                    if (r == `BOARD_ROWS - 1) flags[2] = 1'b1;
                    else if (model_board[r+1][c]) flags[2] = 1'b1;
                    if (c == 0) flags[1] = 1'b1;
                    else if (model_board[r][c-1]) flags[1] = 1'b1;
                    if (c == `BOARD_COLS - 1) flags[0] = 1'b1;
                    else if (model_board[r][c+1]) flags[0] = 1'b1;
                end
            end
        end
        return flags;
    endfunction

    // Merge, then clear full rows from the bottom, staying on a row after a clear
    task automatic settle_lock();
        int r;
        model_board = model_board | overlay_of(model_row, model_col, model_kind);
        r = `BOARD_ROWS - 1;
        while (r >= 0) begin
            if (&model_board[r]) begin
                for (int k = r; k > 0; k--) begin
                    model_board[k] = model_board[k-1];
                end
                model_board[0] = '0;
                if (model_score < `SCORE_MAX) model_score++;
                clear_count++;
            end else begin
                r--;
            end
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        start_i = 1'b0;
        drop_tick_i = 1'b0;
        left_i = 1'b0;
        right_i = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        model_board = '0;
        model_score = 0;
        next_kind = 0;
        clear_count = 0;
    endtask

    task automatic drop_tick(input bit l, input bit r, output bit landed);
        logic [2:0] flags;
        flags = edge_flags(model_row, model_col, model_kind);
        drop_tick_i = 1'b1;
        left_i = l;
        right_i = r;
        next_cycle();
        drop_tick_i = 1'b0;
        left_i = 1'b0;
        right_i = 1'b0;
        landed = flags[2];
        if (landed) begin
            check_value("lock_o", 1, lock_o);
            settle_lock();
        end else begin
            model_row++;
            // Lateral move judged at the old position
            if (l && !flags[1]) model_col--;
            else if (r && !flags[0]) model_col++;
            check_value("lock_o", 0, lock_o);
            check_board("display_o", model_board | overlay_of(model_row, model_col, model_kind),
                        display_o);
        end
    endtask

    // Target far outside the board means a held input
    task automatic land_piece(input int target, input bit random_lat);
        bit landed;
        bit l;
        bit r;
        int pick;
        int n;
        landed = 1'b0;
        n = 0;
        while (!landed && n < TICK_LIMIT) begin
            if (random_lat) begin
                pick = $urandom % 3;
                l = (pick == 1);
                r = (pick == 2);
            end else begin
                l = (model_col > target);
                r = (model_col < target);
            end
            drop_tick(l, r, landed);
            n++;
        end
        if (!landed) begin
            $display("Timeout: the piece did not land within %0d ticks", TICK_LIMIT);
            abort_run();
        end
    endtask

    task automatic await_piece(output bit got_over);
        int n;
        bit over_expected;
        n = 0;
        got_over = 1'b0;
        while (!spawn_o && !game_over_o && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!spawn_o && !game_over_o) begin
            $display("Timeout: neither a spawn nor game over after %0d cycles", WAIT_LIMIT);
            abort_run();
        end else begin
            over_expected = |model_board[0];
            check_value("game_over_o", over_expected, game_over_o);
            check_value("spawn_o", !over_expected, spawn_o);
            check_board("display_o", model_board, display_o);
            check_value("score_o", model_score, score_o);
            got_over = over_expected;
            if (!over_expected) begin
                next_cycle();
                model_row = 0;
                model_col = `SPAWN_COL;
                model_kind = next_kind;
                next_kind = (next_kind + 1) % `PIECE_KINDS;
                check_value("piece_kind_o", model_kind, piece_kind_o);
                check_value("spawn_o", 0, spawn_o);
                check_board("display_o",
                            model_board | overlay_of(model_row, model_col, model_kind),
                            display_o);
            end
        end
    endtask

    task automatic start_game();
        bit over;
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        await_piece(over);
    endtask

    task automatic check_reset_state();
        apply_reset();
        check_board("display_o", '0, display_o);
        check_value("score_o", 0, score_o);
        check_value("game_over_o", 0, game_over_o);
        check_value("spawn_o", 0, spawn_o);
        check_value("lock_o", 0, lock_o);
        // No start, so ticks must do nothing
        repeat (3) begin
            drop_tick_i = 1'b1;
            next_cycle();
            drop_tick_i = 1'b0;
            next_cycle();
            check_board("display_o", '0, display_o);
            check_value("spawn_o", 0, spawn_o);
        end
    endtask

    task automatic spawn_first_piece();
        board_t expected;
        expected = '0;
        start_game();
        for (int r = 0; r < 4; r++) begin
            expected[r][4] = 1'b1;
        end
        check_board("display_o", expected, display_o);
        check_value("piece_kind_o", 0, piece_kind_o);
    endtask

    task automatic fall_and_lock();
        bit landed;
        bit over;
        repeat (16) drop_tick(1'b0, 1'b0, landed);
        drop_tick(1'b0, 1'b0, landed);
        check_value("lock_o", 1, lock_o);
        await_piece(over);
        check_value("display_o rows 16-19", {4{10'h010}},
                    {display_o[19], display_o[18], display_o[17], display_o[16]});
        check_value("piece_kind_o", 1, piece_kind_o);
    endtask

    task automatic lateral_limits();
        bit landed;
        bit over;
        // O piece against both walls
        repeat (5) drop_tick(1'b1, 1'b0, landed);
        check_value("display_o[5][0]", 1, display_o[5][0]);
        repeat (9) drop_tick(1'b0, 1'b1, landed);
        check_value("display_o[14][9]", 1, display_o[14][9]);
        land_piece(model_col, 1'b0);
        await_piece(over);
        // L piece slides left into the I column and is held beside it
        repeat (2) drop_tick(1'b0, 1'b1, landed);
        repeat (12) drop_tick(1'b0, 1'b0, landed);
        land_piece(-8, 1'b0);
        await_piece(over);
        check_value("display_o L cells", 3'b111,
                    {display_o[17][5], display_o[19][5], display_o[19][6]});
    endtask

    task automatic line_clear();
        int targets[8] = '{-1, 7, 0, 4, 2, -1, 1, 6};
        bit over;
        apply_reset();
        start_game();
        foreach (targets[i]) begin
            land_piece(targets[i], 1'b0);
            await_piece(over);
        end
        assert (clear_count > 0) else begin
            $display("The steered pieces did not fill a row");
            abort_run();
        end
        over = 1'b0;
        for (int i = 0; i < 6 && !over; i++) begin
            land_piece(0, 1'b1);
            await_piece(over);
        end
    endtask

    task automatic game_over_run();
        bit over;
        int n;
        apply_reset();
        start_game();
        over = 1'b0;
        n = 0;
        while (!over && n < 40) begin
            land_piece(model_col, 1'b0);
            await_piece(over);
            n++;
        end
        assert (over) else begin
            $display("Game over was not reached after %0d pieces", n);
            abort_run();
        end
        repeat (10) begin
            drop_tick_i = 1'b1;
            start_i = 1'b1;
            next_cycle();
            drop_tick_i = 1'b0;
            start_i = 1'b0;
            check_value("game_over_o", 1, game_over_o);
            check_value("spawn_o", 0, spawn_o);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        start_i = 1'b0;
        drop_tick_i = 1'b0;
        left_i = 1'b0;
        right_i = 1'b0;
        void'($urandom(32'hd2df8ab3));
        check_reset_state();
        spawn_first_piece();
        fall_and_lock();
        lateral_limits();
        line_clear();
        game_over_run();
        $display("*** PASSED ***");
        $finish;
    end

    // Overall limit on simulated time
    initial begin
        #1000000;
        $display("Timeout: simulation time limit reached");
        abort_run();
    end

endmodule

// File: tb.f
+incdir+include
hw/tetris_pkg.sv
hw/game_fsm.sv
hw/piece_mover.sv
hw/piece_geometry.sv
hw/board_store.sv
hw/tetris_core.sv
verif/tetris_tb.sv
